// File: files.f
foveal_pkg.sv
pixel_position.sv
gaze_rank.sv
block_mean.sv
line_packer.sv
foveal_tx_top.sv
foveal_tx_chk.sv
foveal_tx_tb.sv

// File: foveal_tx_tb.sv
`timescale 1ns/100ps

module foveal_tx_tb import foveal_pkg::*; ();

    localparam int LINE_W = 18;
    localparam int LINE_GAP = 2;
    localparam int DRAIN_CYCLES = 20;
    localparam int IDLE_CHECK = 8;
    localparam int TOTAL_LINES = 24;
    localparam int NUM_TESTS = 6;
    localparam int CLK_PERIOD = 10;
    localparam int WATCHDOG_NS = CLK_PERIOD * (10 + TOTAL_LINES * (LINE_W + LINE_GAP)
        + NUM_TESTS * (DRAIN_CYCLES + IDLE_CHECK + 5) + 200);

    logic   w_clk_125 = 1'b0;
    logic   i_rst;
    logic   i_pix_valid;
    logic   i_pix_sof;
    logic   i_pix_eol;
    rgb_t   i_pix_rgb;
    coord_t i_gaze_x;
    coord_t i_gaze_y;
    thres_t i_thres_1;
    thres_t i_thres_2;
    thres_t i_thres_3;
    logic   o_word_valid;
    logic   o_word_eol;
    word_t  o_word;

    word_t       exp_q[$];
    rgb_t        line_pix [LINE_W];
    // model copy of the frame parameters taken at sof
    longint      m_gx;
    longint      m_gy;
    longint      m_t1;
    longint      m_t2;
    longint      m_t3;
    int          m_row;
    int          errors;
    int          checks;
    int          tests_failed;
    int          test_num;
    int          err_at_start;
    int unsigned seed_val;

    always #(CLK_PERIOD / 2) w_clk_125 = ~w_clk_125;

    foveal_tx_top dut_i (
        .w_clk_125    (w_clk_125),
        .i_rst        (i_rst),
        .i_pix_valid  (i_pix_valid),
        .i_pix_sof    (i_pix_sof),
        .i_pix_eol    (i_pix_eol),
        .i_pix_rgb    (i_pix_rgb),
        .i_gaze_x     (i_gaze_x),
        .i_gaze_y     (i_gaze_y),
        .i_thres_1    (i_thres_1),
        .i_thres_2    (i_thres_2),
        .i_thres_3    (i_thres_3),
        .o_word_valid (o_word_valid),
        .o_word_eol   (o_word_eol),
        .o_word       (o_word)
    );

    function automatic int rank_of(input int x, input int y);
        longint dx;
        longint dy;
        longint d;
        dx = x - m_gx;
        dy = y - m_gy;
        d = dx * dx + dy * dy;
        if (d < m_t3) begin
            return 0;
        end else if (d < m_t2) begin
            return 1;
        end else if (d < m_t1) begin
            return 2;
        end
        return 3;
    endfunction

    // groups of rank+1 pixels, cut at the line end, then the trailer
    task automatic queue_line();
        int    x;
        int    r;
        int    n;
        int    count;
        int    sr;
        int    sg;
        int    sb;
        word_t w;
        x = 0;
        count = 0;
        while (x < LINE_W) begin
            r = rank_of(x, m_row);
            n = 0;
            sr = 0;
            sg = 0;
            sb = 0;
            while (n < r + 1 && x < LINE_W) begin
                sr += line_pix[x][23:16];
                sg += line_pix[x][15:8];
                sb += line_pix[x][7:0];
                n++;
                x++;
            end
            w = '0;
            w[25:24] = r[1:0];
            w[23:16] = sr / n;
            w[15:8] = sg / n;
            w[7:0] = sb / n;
            exp_q.push_back(w);
            count++;
        end
        w[31:24] = TRAILER_MARK;
        w[23:12] = count;
        w[11:0] = m_row;
        exp_q.push_back(w);
    endtask

    task automatic set_params(input int gx, input int gy, input int t1, input int t2,
                              input int t3);
        i_gaze_x = coord_t'(gx);
        i_gaze_y = coord_t'(gy);
        i_thres_1 = thres_t'(t1);
        i_thres_2 = thres_t'(t2);
        i_thres_3 = thres_t'(t3);
    endtask

    task automatic randomize_params();
        i_gaze_x = coord_t'($urandom);
        i_gaze_y = coord_t'($urandom);
        i_thres_1 = thres_t'($urandom);
        i_thres_2 = thres_t'($urandom);
        i_thres_3 = thres_t'($urandom);
    endtask

    task automatic send_line(input bit with_sof, input bit scramble);
        int x;
        for (x = 0; x < LINE_W; x++) begin
            line_pix[x] = rgb_t'($urandom);
        end
        if (with_sof) begin
            m_gx = i_gaze_x;
            m_gy = i_gaze_y;
            m_t1 = i_thres_1;
            m_t2 = i_thres_2;
            m_t3 = i_thres_3;
            m_row = 0;
        end
        queue_line();
        for (x = 0; x < LINE_W; x++) begin
            @(negedge w_clk_125);
            i_pix_valid = 1'b1;
            i_pix_sof = with_sof && (x == 0);
            i_pix_eol = (x == LINE_W - 1);
            i_pix_rgb = line_pix[x];
            if (scramble && !(with_sof && x == 0)) begin
                randomize_params();
            end
        end
        @(negedge w_clk_125);
        i_pix_valid = 1'b0;
        i_pix_sof = 1'b0;
        i_pix_eol = 1'b0;
        repeat (LINE_GAP - 1) @(negedge w_clk_125);
        m_row++;
    endtask

    task automatic end_test(input string name);
        int wait_cnt;
        int fails_now;
        wait_cnt = 0;
        while (exp_q.size() != 0 && wait_cnt < DRAIN_CYCLES) begin
            @(posedge w_clk_125);
            wait_cnt++;
        end
        @(negedge w_clk_125);
        if (exp_q.size() != 0) begin
            $display("%s: %0d expected words never came out", name, exp_q.size());
            errors++;
            exp_q.delete();
        end
        // stray words would show up here
        repeat (IDLE_CHECK) @(negedge w_clk_125);
        test_num++;
        fails_now = errors + dut_i.chk_i.fail_count;
        if (fails_now == err_at_start) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            $display("test %0d %s: %0d errors", test_num, name, fails_now - err_at_start);
            tests_failed++;
        end
        err_at_start = fails_now;
    endtask

    always @(negedge w_clk_125) begin : word_monitor
        word_t exp_word;
        if (o_word_valid) begin
            if (exp_q.size() == 0) begin
                $display("word %h came out at %0t with nothing expected", o_word, $time);
                errors++;
            end else begin
                exp_word = exp_q.pop_front();
                checks++;
                assert (o_word === exp_word) else begin
                    $display("[ERROR] %0t o_word expected %h actual %h",
                             $time, exp_word, o_word);
                    errors++;
                end
                assert (o_word_eol === (exp_word[31:24] == TRAILER_MARK)) else begin
                    $display("[ERROR] %0t o_word_eol expected %b actual %b",
                             $time, exp_word[31:24] == TRAILER_MARK, o_word_eol);
                    errors++;
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        seed_val = $urandom(32'h5fe);
        i_rst = 1'b1;
        i_pix_valid = 1'b0;
        i_pix_sof = 1'b0;
        i_pix_eol = 1'b0;
        i_pix_rgb = '0;
        set_params(0, 0, 0, 0, 0);
        m_gx = 0;
        m_gy = 0;
        m_t1 = 0;
        m_t2 = 0;
        m_t3 = 0;
        m_row = 0;
        errors = 0;
        checks = 0;
        tests_failed = 0;
        test_num = 0;
        err_at_start = 0;
        repeat (10) @(posedge w_clk_125);
        @(negedge w_clk_125);
        i_rst = 1'b0;

        // idle first, then lines before any sof
        repeat (5) @(negedge w_clk_125);
        send_line(1'b0, 1'b0);
        send_line(1'b0, 1'b0);
        end_test("reset and no sof");

        set_params(9, 1, 24'hFFFFFF, 24'hFFFFFF, 24'hFFFFFF);
        send_line(1'b1, 1'b0);
        repeat (2) send_line(1'b0, 1'b0);
        end_test("all near");

        set_params(4, 1, 0, 0, 0);
        send_line(1'b1, 1'b0);
        repeat (2) send_line(1'b0, 1'b0);
        end_test("all far");

        set_params(9, 2, 60, 20, 5);
        send_line(1'b1, 1'b0);
        repeat (4) send_line(1'b0, 1'b0);
        end_test("mixed ranks");

        // inputs move every pixel after sof
        set_params(5, 3, 40, 12, 3);
        send_line(1'b1, 1'b1);
        repeat (4) send_line(1'b0, 1'b1);
        end_test("parameter latch");

        set_params(12, 1, 50, 18, 6);
        send_line(1'b1, 1'b0);
        repeat (2) send_line(1'b0, 1'b0);
        set_params(3, 0, 30, 10, 2);
        send_line(1'b1, 1'b0);
        repeat (2) send_line(1'b0, 1'b0);
        end_test("trailers");

        $display("tests %0d, failed %0d, words checked %0d, errors %0d, assertion fails %0d",
                 test_num, tests_failed, checks, errors, dut_i.chk_i.fail_count);
        if (errors == 0 && dut_i.chk_i.fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: foveal_tx_chk.sv
`timescale 1ns/100ps

module foveal_tx_chk import foveal_pkg::*; (
    input logic  i_clk,
    input logic  i_rst,
    input logic  i_pix_valid,
    input logic  i_pix_eol,
    input logic  i_word_valid,
    input logic  i_word_eol,
    input word_t i_word
);

    // set by the first valid pixel after reset
    logic r_pix_seen;

    // assertion failures so far
    int fail_count = 0;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_pix_seen <= 1'b0;
        end else if (i_pix_valid) begin
            r_pix_seen <= 1'b1;
        end
    end

    // output strobe cleared by reset
    a_reset_quiet: assert property (@(posedge i_clk)
        i_rst |=> !i_word_valid)
        else begin
            $error("word strobe high after a reset cycle");
            fail_count++;
        end

    // nothing can come out before the first pixel has crossed the pipeline
    a_start_quiet: assert property (@(posedge i_clk) disable iff (i_rst)
        !$past(r_pix_seen, LATENCY_GROUP - 1) |-> !i_word_valid)
        else begin
            $error("word strobe high before the first pixel could arrive");
            fail_count++;
        end

    // every word traces back to a pixel or an eol pixel
    a_word_source: assert property (@(posedge i_clk) disable iff (i_rst)
        i_word_valid |-> $past(i_pix_valid, LATENCY_GROUP)
            || $past(i_pix_valid && i_pix_eol, LATENCY_TRAILER))
        else begin
            $error("word strobe without a matching pixel");
            fail_count++;
        end

    // trailer follows each eol pixel at a fixed distance
    a_trailer_time: assert property (@(posedge i_clk) disable iff (i_rst)
        i_word_eol == $past(i_pix_valid && i_pix_eol, LATENCY_TRAILER))
        else begin
            $error("trailer strobe does not match an eol pixel");
            fail_count++;
        end

    // group words hold the rank in the top byte
    a_group_rank: assert property (@(posedge i_clk) disable iff (i_rst)
        i_word_valid && !i_word_eol |-> i_word[31:24] <= 8'd3)
        else begin
            $error("group word top byte above 3");
            fail_count++;
        end

endmodule

bind foveal_tx_top foveal_tx_chk chk_i (
    .i_clk        (w_clk_125),
    .i_rst        (i_rst),
    .i_pix_valid  (i_pix_valid),
    .i_pix_eol    (i_pix_eol),
    .i_word_valid (o_word_valid),
    .i_word_eol   (o_word_eol),
    .i_word       (o_word)
);

// File: foveal_tx_top.sv
`timescale 1ns/100ps

module foveal_tx_top import foveal_pkg::*; (
    input  logic   w_clk_125,
    input  logic   i_rst,
    input  logic   i_pix_valid,
    input  logic   i_pix_sof,
    input  logic   i_pix_eol,
    input  rgb_t   i_pix_rgb,
    input  coord_t i_gaze_x,
    input  coord_t i_gaze_y,
    input  thres_t i_thres_1,
    input  thres_t i_thres_2,
    input  thres_t i_thres_3,
    output logic   o_word_valid,
    output logic   o_word_eol,
    output word_t  o_word
);

    // pixel with its coordinates, one cycle in
    logic   w_pos_valid;
    logic   w_pos_sof;
    logic   w_pos_eol;
    coord_t w_pos_x;
    coord_t w_pos_y;
    rgb_t   w_pos_rgb;

    // ranked pixel, three cycles in
    logic   w_rank_valid;
    logic   w_rank_eol;
    coord_t w_rank_y;
    rgb_t   w_rank_rgb;
    rank_t  w_rank;

    // closed groups, four cycles in
    logic   w_group_valid;
    logic   w_line_end;
    rank_t  w_group_rank;
    rgb_t   w_group_mean;
    coord_t w_group_row;

    pixel_position u_pixel_position (
        .i_clk       (w_clk_125),
        .i_rst       (i_rst),
        .i_pix_valid (i_pix_valid),
        .i_pix_sof   (i_pix_sof),
        .i_pix_eol   (i_pix_eol),
        .i_pix_rgb   (i_pix_rgb),
        .o_valid     (w_pos_valid),
        .o_sof       (w_pos_sof),
        .o_eol       (w_pos_eol),
        .o_x         (w_pos_x),
        .o_y         (w_pos_y),
        .o_rgb       (w_pos_rgb)
    );

    gaze_rank u_gaze_rank (
        .i_clk       (w_clk_125),
        .i_rst       (i_rst),
        .i_pix_valid (i_pix_valid),
        .i_pix_sof   (i_pix_sof),
        .i_valid     (w_pos_valid),
        .i_sof       (w_pos_sof),
        .i_eol       (w_pos_eol),
        .i_x         (w_pos_x),
        .i_y         (w_pos_y),
        .i_rgb       (w_pos_rgb),
        .i_gaze_x    (i_gaze_x),
        .i_gaze_y    (i_gaze_y),
        .i_thres_1   (i_thres_1),
        .i_thres_2   (i_thres_2),
        .i_thres_3   (i_thres_3),
        .o_valid     (w_rank_valid),
        .o_eol       (w_rank_eol),
        .o_y         (w_rank_y),
        .o_rgb       (w_rank_rgb),
        .o_rank      (w_rank)
    );

    block_mean u_block_mean (
        .i_clk         (w_clk_125),
        .i_rst         (i_rst),
        .i_valid       (w_rank_valid),
        .i_eol         (w_rank_eol),
        .i_rank        (w_rank),
        .i_rgb         (w_rank_rgb),
        .i_y           (w_rank_y),
        .o_group_valid (w_group_valid),
        .o_line_end    (w_line_end),
        .o_rank        (w_group_rank),
        .o_mean        (w_group_mean),
        .o_row         (w_group_row)
    );

    line_packer u_line_packer (
        .i_clk         (w_clk_125),
        .i_rst         (i_rst),
        .i_group_valid (w_group_valid),
        .i_line_end    (w_line_end),
        .i_rank        (w_group_rank),
        .i_mean        (w_group_mean),
        .i_row         (w_group_row),
        .o_word_valid  (o_word_valid),
        .o_word_eol    (o_word_eol),
        .o_word        (o_word)
    );

endmodule

// File: line_packer.sv
`timescale 1ns/100ps

module line_packer import foveal_pkg::*; (
    input  logic   i_clk,
    input  logic   i_rst,
    input  logic   i_group_valid,
    input  logic   i_line_end,
    input  rank_t  i_rank,
    input  rgb_t   i_mean,
    input  coord_t i_row,
    output logic   o_word_valid,
    output logic   o_word_eol,
    output word_t  o_word
);

    coord_t r_count;
    coord_t r_row;
    logic   r_trailer;
    coord_t w_count_next;

    assign w_count_next = r_count + 1'b1;

    // trailer goes out one cycle after the last group word
    // the idle cycle after each eol keeps that slot free
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_word_valid <= 1'b0;
            o_word_eol   <= 1'b0;
            r_trailer    <= 1'b0;
            r_count      <= '0;
        end else begin
            o_word_valid <= r_trailer | i_group_valid;
            o_word_eol   <= r_trailer;
            r_trailer    <= ~r_trailer & i_group_valid & i_line_end;
            if (r_trailer) begin
                r_count <= '0;
            end else if (i_group_valid) begin
                r_count <= w_count_next;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (r_trailer) begin
            o_word <= {TRAILER_MARK, r_count, r_row};
        end else if (i_group_valid) begin
            // rank in the top byte keeps it below the trailer mark
            o_word <= {6'd0, i_rank, i_mean};
        end
        if (i_group_valid && i_line_end) begin
            r_row <= i_row;
        end
    end

endmodule

// File: block_mean.sv
`timescale 1ns/100ps

module block_mean import foveal_pkg::*; (
    input  logic   i_clk,
    input  logic   i_rst,
    input  logic   i_valid,
    input  logic   i_eol,
    input  rank_t  i_rank,
    input  rgb_t   i_rgb,
    input  coord_t i_y,
    output logic   o_group_valid,
    output logic   o_line_end,
    output rank_t  o_rank,
    output rgb_t   o_mean,
    output coord_t o_row
);

    // open group
    logic       r_open;
    rank_t      r_rank;
    logic [2:0] r_cnt;
    acc_t       r_acc_r;
    acc_t       r_acc_g;
    acc_t       r_acc_b;

    chan_t      w_pix_r;
    chan_t      w_pix_g;
    chan_t      w_pix_b;
    rank_t      w_rank;
    logic [2:0] w_cnt;
    acc_t       w_sum_r;
    acc_t       w_sum_g;
    acc_t       w_sum_b;
    logic       w_close;

    // truncated sum/cnt for a count of 1 to 4
    function automatic chan_t div_count(input acc_t sum, input logic [2:0] cnt);
        logic [20:0] prod;
        prod = sum * DIV3_MUL;
        case (cnt)
            3'd2:    div_count = sum[8:1];
            3'd3:    div_count = prod[DIV3_SHIFT +: 8];
            3'd4:    div_count = sum[9:2];
            default: div_count = sum[7:0];
        endcase
    endfunction

    assign w_pix_r = i_rgb[23:16];
    assign w_pix_g = i_rgb[15:8];
    assign w_pix_b = i_rgb[7:0];

    always_comb begin
        if (r_open) begin
            w_rank  = r_rank;
            w_cnt   = r_cnt + 3'd1;
            w_sum_r = r_acc_r + {2'b00, w_pix_r};
            w_sum_g = r_acc_g + {2'b00, w_pix_g};
            w_sum_b = r_acc_b + {2'b00, w_pix_b};
        end else begin
            // opening pixel fixes the size of the whole group
            w_rank  = i_rank;
            w_cnt   = 3'd1;
            w_sum_r = {2'b00, w_pix_r};
            w_sum_g = {2'b00, w_pix_g};
            w_sum_b = {2'b00, w_pix_b};
        end
        // full group, or cut short at the end of the line
        w_close = i_eol || (w_cnt == ({1'b0, w_rank} + 3'd1));
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_open        <= 1'b0;
            o_group_valid <= 1'b0;
            o_line_end    <= 1'b0;
        end else begin
            o_group_valid <= i_valid & w_close;
            o_line_end    <= i_valid & i_eol;
            if (i_valid) begin
                r_open <= ~w_close;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            r_rank  <= w_rank;
            r_cnt   <= w_cnt;
            r_acc_r <= w_sum_r;
            r_acc_g <= w_sum_g;
            r_acc_b <= w_sum_b;
            if (w_close) begin
                o_rank <= w_rank;
                o_mean <= {div_count(w_sum_r, w_cnt),
                           div_count(w_sum_g, w_cnt),
                           div_count(w_sum_b, w_cnt)};
                o_row  <= i_y;
            end
        end
    end

endmodule

// File: gaze_rank.sv
`timescale 1ns/100ps

module gaze_rank import foveal_pkg::*; (
    input  logic   i_clk,
    input  logic   i_rst,
    input  logic   i_pix_valid,
    input  logic   i_pix_sof,
    input  logic   i_valid,
    input  logic   i_sof,
    input  logic   i_eol,
    input  coord_t i_x,
    input  coord_t i_y,
    input  rgb_t   i_rgb,
    input  coord_t i_gaze_x,
    input  coord_t i_gaze_y,
    input  thres_t i_thres_1,
    input  thres_t i_thres_2,
    input  thres_t i_thres_3,
    output logic   o_valid,
    output logic   o_eol,
    output coord_t o_y,
    output rgb_t   o_rgb,
    output rank_t  o_rank
);

    coord_t r_gaze_x;
    coord_t r_gaze_y;
    thres_t r_thres_1;
    thres_t r_thres_2;
    thres_t r_thres_3;
    // second copy follows the sof pixel into the compare step
    thres_t r_cmp_1;
    thres_t r_cmp_2;
    thres_t r_cmp_3;

    logic   r_valid_2;
    logic   r_eol_2;
    coord_t r_y_2;
    rgb_t   r_rgb_2;
    dist_t  r_sq_x;
    dist_t  r_sq_y;

    logic signed [12:0] w_dx;
    logic signed [12:0] w_dy;
    logic signed [25:0] w_sq_x;
    logic signed [25:0] w_sq_y;
    dist_t              w_dist;

    // frame parameters are taken from the top-level sof pixel
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_gaze_x  <= '0;
            r_gaze_y  <= '0;
            r_thres_1 <= '0;
            r_thres_2 <= '0;
            r_thres_3 <= '0;
            r_cmp_1   <= '0;
            r_cmp_2   <= '0;
            r_cmp_3   <= '0;
        end else begin
            if (i_pix_valid && i_pix_sof) begin
                r_gaze_x  <= i_gaze_x;
                r_gaze_y  <= i_gaze_y;
                r_thres_1 <= i_thres_1;
                r_thres_2 <= i_thres_2;
                r_thres_3 <= i_thres_3;
            end
            if (i_valid && i_sof) begin
                r_cmp_1 <= r_thres_1;
                r_cmp_2 <= r_thres_2;
                r_cmp_3 <= r_thres_3;
            end
        end
    end

    assign w_dx   = $signed({1'b0, i_x}) - $signed({1'b0, r_gaze_x});
    assign w_dy   = $signed({1'b0, i_y}) - $signed({1'b0, r_gaze_y});
    assign w_sq_x = w_dx * w_dx;
    assign w_sq_y = w_dy * w_dy;

    // squares are never negative, so the low bits hold the magnitude
    assign w_dist = r_sq_x + r_sq_y;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_valid_2 <= 1'b0;
            r_eol_2   <= 1'b0;
            o_valid   <= 1'b0;
            o_eol     <= 1'b0;
        end else begin
            r_valid_2 <= i_valid;
            r_eol_2   <= i_eol;
            o_valid   <= r_valid_2;
            o_eol     <= r_eol_2;
        end
    end

    always_ff @(posedge i_clk) begin
        r_sq_x  <= w_sq_x[24:0];
        r_sq_y  <= w_sq_y[24:0];
        r_y_2   <= i_y;
        r_rgb_2 <= i_rgb;
        o_y     <= r_y_2;
        o_rgb   <= r_rgb_2;
        // smallest threshold wins, thresholds fall from 1 to 3
        if (w_dist < {1'b0, r_cmp_3}) begin
            o_rank <= 2'd0;
        end else if (w_dist < {1'b0, r_cmp_2}) begin
            o_rank <= 2'd1;
        end else if (w_dist < {1'b0, r_cmp_1}) begin
            o_rank <= 2'd2;
        end else begin
            o_rank <= RANK_FAR;
        end
    end

endmodule

// File: pixel_position.sv
`timescale 1ns/100ps

module pixel_position import foveal_pkg::*; (
    input  logic   i_clk,
    input  logic   i_rst,
    input  logic   i_pix_valid,
    input  logic   i_pix_sof,
    input  logic   i_pix_eol,
    input  rgb_t   i_pix_rgb,
    output logic   o_valid,
    output logic   o_sof,
    output logic   o_eol,
    output coord_t o_x,
    output coord_t o_y,
    output rgb_t   o_rgb
);

    coord_t r_col;
    coord_t r_row;
    coord_t w_x;
    coord_t w_y;

    // a sof pixel is column 0 of row 0 whatever the counters hold
    assign w_x = i_pix_sof ? '0 : r_col;
    assign w_y = i_pix_sof ? '0 : r_row;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_col <= '0;
            r_row <= '0;
        end else if (i_pix_valid) begin
            if (i_pix_eol) begin
                // next line starts at column 0
                r_col <= '0;
                r_row <= w_y + 1'b1;
            end else begin
                r_col <= w_x + 1'b1;
                r_row <= w_y;
            end
        end
    end

    // markers are qualified with valid here so later stages need not
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_valid <= 1'b0;
            o_sof   <= 1'b0;
            o_eol   <= 1'b0;
        end else begin
            o_valid <= i_pix_valid;
            o_sof   <= i_pix_valid & i_pix_sof;
            o_eol   <= i_pix_valid & i_pix_eol;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_pix_valid) begin
            o_x   <= w_x;
            o_y   <= w_y;
            o_rgb <= i_pix_rgb;
        end
    end

endmodule

// File: foveal_pkg.sv
package foveal_pkg;

    // column or row index, also used for the gaze point
    typedef logic [11:0] coord_t;

    // one colour channel
    typedef logic [7:0] chan_t;

    // packed pixel, red in the top byte, blue in the bottom byte
    typedef logic [23:0] rgb_t;

    // squared-distance threshold as loaded at frame start
    typedef logic [23:0] thres_t;

    // sum of two squared 12-bit differences needs one extra bit
    typedef logic [24:0] dist_t;

    // rank 0 is nearest the gaze, group size is rank+1 pixels
    typedef logic [1:0] rank_t;

    // per-channel sum of up to four pixels
    typedef logic [9:0] acc_t;

    // one output word
    typedef logic [31:0] word_t;

    // rank used when no threshold is met
    localparam rank_t RANK_FAR = 2'd3;

    // top byte of a trailer word
    // group words carry the rank there, which never exceeds 3
    localparam logic [7:0] TRAILER_MARK = 8'hE0;

    // reciprocal of 3 in 11 fractional bits
    // exact truncated quotient for every acc_t value
    localparam logic [10:0] DIV3_MUL = 11'd683;
    localparam int DIV3_SHIFT = 11;

    // cycles from the last pixel of a group to its word
    localparam int LATENCY_GROUP = 5;

    // cycles from an eol pixel to the trailer word
    localparam int LATENCY_TRAILER = 6;

endpackage
